/* list.f */
verilog/bus_pkg.sv
verilog/cache_pkg.sv
verilog/cache_array_if.sv
verilog/cache_tag_array.sv
verilog/cache_data_array.sv
verilog/l1_cache_ctrl.sv
verilog/l1_cache_top.sv
tb/cache_checker.sv
tb/tb_l1_cache.sv

/* run.sh */
#!/bin/sh
# Build and run the L1 cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module tb_l1_cache -f list.f -o tb_l1_cache \
	&& ./obj_dir/tb_l1_cache > sim.log 2>&1 \
	|| echo "Build or simulation step returned an error"

cat sim.log 2>/dev/null

grep -q "Finished with no errors" sim.log && echo "PASS" && exit 0 \
	|| echo "FAIL" && exit 1

/* tb/cache_checker.sv */
/*
 * Cache checker
 * Shadow of architectural memory and a copy of memory-side writes,
 * compares read data and the memory content after flush
 */

`timescale 1ns/1ps

module cache_checker import bus_pkg::*; #(
	parameter logic [addr_width-1:0] NONCACHE_START_ADDR = 32'h8000_0000
) (
	input logic tb_CLK,
	input logic rst_n,
	input logic [addr_width-1:0] proc_addr,
	input logic [data_width-1:0] proc_wdata,
	input logic proc_ren,
	input logic proc_wen,
	input logic [data_width-1:0] proc_rdata,
	input logic proc_busy,
	input logic [addr_width-1:0] mem_addr,
	input logic [data_width-1:0] mem_wdata,
	input logic mem_ren,
	input logic mem_wen,
	input logic mem_busy,
	input logic flush_done,
	input logic clear_done,
	input logic exp_check,
	input logic [data_width-1:0] exp_rdata,
	output int check_count,
	output int error_count
);

	// What the CPU should read back
	logic [data_width-1:0] shadow [logic [addr_width-1:0]];
	// What really reached memory
	logic [data_width-1:0] mem_copy [logic [addr_width-1:0]];
	int checks = 0;
	int errors = 0;
	int bypass_words = 0;
	logic done_prev = 1'b0;

	assign check_count = checks;
	assign error_count = errors;

	function automatic logic [addr_width-1:0] word_addr(input logic [addr_width-1:0] a);
		return {a[addr_width-1:2], 2'b00};
	endfunction

	function automatic logic [data_width-1:0] init_word(input logic [addr_width-1:0] a);
		return word_addr(a) ^ 32'h5a5a_5a5a;
	endfunction

	function automatic logic [data_width-1:0] shadow_value(input logic [addr_width-1:0] a);
		return shadow.exists(word_addr(a)) ? shadow[word_addr(a)] : init_word(a);
	endfunction

	function automatic logic [data_width-1:0] memory_value(input logic [addr_width-1:0] a);
		return mem_copy.exists(word_addr(a)) ? mem_copy[word_addr(a)] : init_word(a);
	endfunction

	task automatic compare(input string what, input logic [addr_width-1:0] addr,
		input logic [data_width-1:0] got, input logic [data_width-1:0] expected);
		checks++;
		if (got !== expected)
		begin
			errors++;
			$display("MISMATCH at %0t: %s 0x%08h got 0x%08h, expected 0x%08h",
				$time, what, addr, got, expected);
		end
	endtask

	// Outputs settle well before the falling edge
	always @(negedge tb_CLK)
	begin
		if (rst_n)
		begin
			if ((mem_ren || mem_wen) && !mem_busy)
			begin
				if (mem_wen)
					mem_copy[word_addr(mem_addr)] = mem_wdata;
				// Uncached word must match the CPU request
				if (mem_addr >= NONCACHE_START_ADDR)
				begin
					bypass_words++;
					if (mem_addr != proc_addr || mem_wen != proc_wen)
					begin
						errors++;
						$display("Uncached transfer at 0x%08h does not match request at 0x%08h",
							mem_addr, proc_addr);
					end
				end
			end
			if ((proc_ren || proc_wen) && !proc_busy)
			begin
				if (proc_addr >= NONCACHE_START_ADDR)
				begin
					if (bypass_words != 1)
					begin
						errors++;
						$display("Uncached access at 0x%08h used %0d memory words, not one",
							proc_addr, bypass_words);
					end
					bypass_words = 0;
				end
				if (proc_wen)
					shadow[word_addr(proc_addr)] = proc_wdata;
				else
				begin
					compare("read", proc_addr, proc_rdata, shadow_value(proc_addr));
					if (exp_check)
						compare("table read", proc_addr, proc_rdata, exp_rdata);
				end
			end
			// Every written word reached memory
			if (flush_done)
				foreach (shadow[a])
					compare("flushed word", a, memory_value(a), shadow[a]);
			// Dirty data gone, memory is the truth again
			if (clear_done)
				foreach (shadow[a])
					shadow[a] = memory_value(a);
			if ((flush_done || clear_done) && done_prev)
			begin
				errors++;
				$display("Done pulse at %0t lasted more than one cycle", $time);
			end
			done_prev = flush_done || clear_done;
		end
	end

endmodule

/* tb/tb_l1_cache.sv */
/*
 * L1 cache testbench
 * Table-driven CPU reads, writes, flush and clear against the cache,
 * with a main memory model that answers the memory bus
 */

`timescale 1ns/1ps

module tb_l1_cache import bus_pkg::*;;

	localparam logic [addr_width-1:0] uncached_base = 32'h8000_0000;
	localparam int num_entries = 25;
	// Cycles allowed for a done pulse after a strobe
	localparam int done_limit = 300;
	localparam int timeout_cycles = 40 * num_entries + 200;

	typedef enum logic [1:0]
	{
		op_read,
		op_write,
		op_flush,
		op_clear
	} op_t;

	// One table row, expected used by reads only
	typedef struct packed
	{
		op_t op;
		logic [addr_width-1:0] addr;
		logic [data_width-1:0] wdata;
		logic [data_width-1:0] expected;
	} entry_t;

	logic tb_CLK = 1'b0;
	logic rst_n;
	logic [addr_width-1:0] proc_addr;
	logic [data_width-1:0] proc_wdata;
	logic proc_ren;
	logic proc_wen;
	logic [data_width-1:0] proc_rdata;
	logic proc_busy;
	logic [addr_width-1:0] mem_addr;
	logic [data_width-1:0] mem_wdata;
	logic mem_ren;
	logic mem_wen;
	logic [data_width-1:0] mem_rdata;
	logic mem_busy;
	logic flush;
	logic clear;
	logic flush_done;
	logic clear_done;

	// Expected read value handed to the checker
	logic exp_check;
	logic [data_width-1:0] exp_rdata;

	entry_t entries [num_entries];
	int entry_count = 0;
	int other_errors = 0;
	int cycles = 0;
	int chk_checks;
	int chk_errors;

	// Main memory, words not yet written follow the fill rule
	logic [data_width-1:0] mem_words [logic [addr_width-1:0]];

	l1_cache_top #(
		.CACHE_SIZE(64),
		.BLOCK_SIZE(4),
		.NONCACHE_START_ADDR(uncached_base)
	) dut_i (
		.tb_CLK(tb_CLK),
		.rst_n(rst_n),
		.proc_addr(proc_addr),
		.proc_wdata(proc_wdata),
		.proc_ren(proc_ren),
		.proc_wen(proc_wen),
		.proc_rdata(proc_rdata),
		.proc_busy(proc_busy),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_ren(mem_ren),
		.mem_wen(mem_wen),
		.mem_rdata(mem_rdata),
		.mem_busy(mem_busy),
		.flush(flush),
		.clear(clear),
		.flush_done(flush_done),
		.clear_done(clear_done)
	);

	cache_checker #(
		.NONCACHE_START_ADDR(uncached_base)
	) chk_i (
		.tb_CLK(tb_CLK),
		.rst_n(rst_n),
		.proc_addr(proc_addr),
		.proc_wdata(proc_wdata),
		.proc_ren(proc_ren),
		.proc_wen(proc_wen),
		.proc_rdata(proc_rdata),
		.proc_busy(proc_busy),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_ren(mem_ren),
		.mem_wen(mem_wen),
		.mem_busy(mem_busy),
		.flush_done(flush_done),
		.clear_done(clear_done),
		.exp_check(exp_check),
		.exp_rdata(exp_rdata),
		.check_count(chk_checks),
		.error_count(chk_errors)
	);

	always #10 tb_CLK = ~tb_CLK;

	function automatic logic [addr_width-1:0] word_addr(input logic [addr_width-1:0] a);
		return {a[addr_width-1:2], 2'b00};
	endfunction

	// Power-up memory content
	function automatic logic [data_width-1:0] init_word(input logic [addr_width-1:0] a);
		return word_addr(a) ^ 32'h5a5a_5a5a;
	endfunction

	function automatic logic [data_width-1:0] mem_read(input logic [addr_width-1:0] a);
		if (mem_words.exists(word_addr(a)))
			return mem_words[word_addr(a)];
		return init_word(a);
	endfunction

	task automatic add_entry(input op_t op, input logic [addr_width-1:0] addr,
		input logic [data_width-1:0] wdata, input logic [data_width-1:0] expected);
		entries[entry_count] = '{op, addr, wdata, expected};
		entry_count++;
	endtask

	// Set 4 is hit by tags 0, 1 and 2 at a stride of 0x80
	task automatic build_table();
		add_entry(op_read, 32'h0000_0010, '0, init_word(32'h0000_0010));
		add_entry(op_read, 32'h0000_0010, '0, init_word(32'h0000_0010));
		add_entry(op_read, 32'h0000_0014, '0, init_word(32'h0000_0014));
		add_entry(op_read, 32'h0000_001c, '0, init_word(32'h0000_001c));
		add_entry(op_write, 32'h0000_0018, 32'h1111_0001, '0);
		add_entry(op_read, 32'h0000_0018, '0, 32'h1111_0001);
		add_entry(op_write, 32'h0000_0040, 32'h2222_0001, '0);
		add_entry(op_write, 32'h0000_00c0, 32'h2222_0002, '0);
		add_entry(op_read, 32'h0000_0044, '0, init_word(32'h0000_0044));
		add_entry(op_write, 32'h0000_0148, 32'h2222_0003, '0);
		add_entry(op_read, 32'h0000_00c0, '0, 32'h2222_0002);
		add_entry(op_read, 32'h0000_0040, '0, 32'h2222_0001);
		add_entry(op_write, 32'h8000_0020, 32'h3333_0001, '0);
		add_entry(op_read, 32'h8000_0020, '0, 32'h3333_0001);
		add_entry(op_read, 32'h8000_0100, '0, init_word(32'h8000_0100));
		add_entry(op_flush, '0, '0, '0);
		add_entry(op_read, 32'h0000_0018, '0, 32'h1111_0001);
		add_entry(op_write, 32'h0000_0050, 32'h4444_0001, '0);
		add_entry(op_write, 32'h0000_0018, 32'h4444_0002, '0);
		// Both dirty words above are lost here
		add_entry(op_clear, '0, '0, '0);
		add_entry(op_read, 32'h0000_0050, '0, init_word(32'h0000_0050));
		add_entry(op_read, 32'h0000_0018, '0, 32'h1111_0001);
		add_entry(op_read, 32'h0000_0148, '0, 32'h2222_0003);
		add_entry(op_write, 32'h0000_0300, 32'h5555_0001, '0);
		add_entry(op_read, 32'h0000_0300, '0, 32'h5555_0001);
	endtask

	// Starts at posedge plus 2 ns and ends there
	task automatic run_entry(input entry_t e);
		bit seen;
		seen = 1'b0;
		case (e.op)
			op_read, op_write:
			begin
				proc_addr = e.addr;
				proc_wdata = e.wdata;
				proc_ren = e.op == op_read;
				proc_wen = e.op == op_write;
				exp_check = e.op == op_read;
				exp_rdata = e.expected;
				// Held up to the completing cycle
				@(negedge tb_CLK);
				while (proc_busy)
					@(negedge tb_CLK);
			end
			default:
			begin
				flush = e.op == op_flush;
				clear = e.op == op_clear;
				@(posedge tb_CLK);
				#2;
				flush = 1'b0;
				clear = 1'b0;
				for (int n = 0; n < done_limit && !seen; n++)
				begin
					@(negedge tb_CLK);
					seen = (e.op == op_flush) ? flush_done : clear_done;
				end
				if (!seen)
				begin
					other_errors++;
					$display("No %s done pulse within %0d cycles",
						(e.op == op_flush) ? "flush" : "clear", done_limit);
				end
			end
		endcase
		@(posedge tb_CLK);
		#2;
		proc_ren = 1'b0;
		proc_wen = 1'b0;
		exp_check = 1'b0;
	endtask

	// Memory model, one word per transfer with 0 to 3 wait cycles
	initial
	begin
		int wait_left;
		logic req_active;
		void'($urandom(32'h952f_cbe8));
		mem_busy = 1'b0;
		mem_rdata = '0;
		wait_left = 0;
		req_active = 1'b0;
		forever
		begin
			@(posedge tb_CLK);
			#2;
			if (mem_ren || mem_wen)
			begin
				if (!req_active)
				begin
					req_active = 1'b1;
					wait_left = int'($urandom_range(3, 0));
				end
				else if (wait_left > 0)
					wait_left--;
				mem_busy = wait_left != 0;
				mem_rdata = mem_read(mem_addr);
			end
			else
			begin
				req_active = 1'b0;
				mem_busy = 1'b0;
			end
			@(negedge tb_CLK);
			// Word accepted this cycle
			if ((mem_ren || mem_wen) && !mem_busy)
			begin
				req_active = 1'b0;
				if (mem_wen)
					mem_words[word_addr(mem_addr)] = mem_wdata;
			end
		end
	end

	// Run limit from the table length
	always @(posedge tb_CLK)
	begin
		cycles++;
		if (cycles >= timeout_cycles)
		begin
			$display("Timeout after %0d cycles, the run did not finish", cycles);
			$display("Finished with errors");
			$finish;
		end
	end

	initial
	begin
		rst_n = 1'b0;
		proc_addr = '0;
		proc_wdata = '0;
		proc_ren = 1'b0;
		proc_wen = 1'b0;
		flush = 1'b0;
		clear = 1'b0;
		exp_check = 1'b0;
		exp_rdata = '0;
		build_table();
		repeat (4) @(posedge tb_CLK);
		#2;
		rst_n = 1'b1;
		for (int i = 0; i < num_entries; i++)
			run_entry(entries[i]);
		repeat (2) @(posedge tb_CLK);
		$display("Checks: %0d, checker errors: %0d, other errors: %0d",
			chk_checks, chk_errors, other_errors);
		if (chk_errors == 0 && other_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* verilog/bus_pkg.sv */
/*
 * Bus package for the L1 cache
 * Word bus widths and the kinds of memory-side transfers
 */

package bus_pkg;

	// Processor and memory buses carry byte addresses and full words
	localparam int addr_width = 32;
	localparam int data_width = 32;

	// Memory-side transfer kinds
	typedef enum logic [2:0]
	{
		mem_idle,
		mem_fill,
		mem_writeback,
		mem_bypass_rd,
		mem_bypass_wr
	} mem_op_t;

endpackage

/* verilog/cache_array_if.sv */
/*
 * Cache array interface
 * Lookup, fill and metadata update signals between controller and arrays
 */

`timescale 1ns/1ps

interface cache_array_if import bus_pkg::*, cache_pkg::*; #(
	parameter int CACHE_SIZE = 64,
	parameter int BLOCK_SIZE = 4
) ();

	localparam int num_sets = CACHE_SIZE / (BLOCK_SIZE * num_ways);
	localparam int idx_w = $clog2(num_sets);
	localparam int off_w = $clog2(BLOCK_SIZE);

	// Controller side
	logic [idx_w-1:0] index;
	logic [addr_width-1:0] lookup_tag;
	logic [off_w-1:0] offset;
	logic way_sel;
	logic data_we;
	logic [data_width-1:0] wdata;
	logic tag_we;
	way_meta_t new_meta;
	logic lru_we;
	logic inv_all;

	// Array side
	logic hit;
	logic hit_way;
	logic [data_width-1:0] rdata;
	logic victim_way;
	// Metadata of the way in way_sel
	way_meta_t victim_meta;

	modport ctrl (
		output index, lookup_tag, offset, way_sel, data_we, wdata,
		output tag_we, new_meta, lru_we, inv_all,
		input hit, hit_way, rdata, victim_way, victim_meta
	);

	modport tag (
		input index, lookup_tag, way_sel, tag_we, new_meta, lru_we, inv_all,
		output hit, hit_way, victim_way, victim_meta
	);

	modport data (
		input index, offset, way_sel, data_we, wdata,
		output rdata
	);

endinterface

/* verilog/cache_data_array.sv */
/*
 * Cache data array
 * Line words per set and way, combinational word read,
 * one word written per enabled cycle
 */

`timescale 1ns/1ps

module cache_data_array import bus_pkg::*, cache_pkg::*; #(
	parameter int CACHE_SIZE = 64,
	parameter int BLOCK_SIZE = 4
) (
	input logic tb_CLK,
	cache_array_if.data arr
);

	localparam int num_sets = CACHE_SIZE / (BLOCK_SIZE * num_ways);
	localparam int idx_w = $clog2(num_sets);
	localparam int off_w = $clog2(BLOCK_SIZE);
	localparam int way_w = $clog2(num_ways);

	// One flat word store, CACHE_SIZE words
	logic [data_width-1:0] words [CACHE_SIZE];

	// Word address is set, then way, then word in line
	logic [idx_w+way_w+off_w-1:0] word_addr;

	assign word_addr = {arr.index, arr.way_sel, arr.offset};

	// Hit data and write-back data come from here
	assign arr.rdata = words[word_addr];

	// Fill words and CPU write hits share this port
	always_ff @(posedge tb_CLK)
	begin
		if (arr.data_we)
			words[word_addr] <= arr.wdata;
	end

endmodule

/* verilog/cache_pkg.sv */
/*
 * Cache package
 * Fixed associativity, controller states and per-way line metadata
 */

package cache_pkg;

	// Two ways and one LRU bit per set
	localparam int num_ways = 2;

	// Controller FSM states
	typedef enum logic [2:0]
	{
		s_idle,
		s_writeback,
		s_fill,
		s_bypass,
		s_flush_scan,
		s_flush_wb,
		s_clear,
		s_done
	} cache_state_t;

	// One way of one set
	// Tag kept at bus width, upper bits zero
	typedef struct packed
	{
		logic valid;
		logic dirty;
		logic [bus_pkg::addr_width-1:0] tag;
	} way_meta_t;

endpackage

/* verilog/cache_tag_array.sv */
/*
 * Cache tag array
 * Valid, dirty, tag and LRU state per set, with hit detection
 * and victim choice for the two ways
 */

`timescale 1ns/1ps

module cache_tag_array import bus_pkg::*, cache_pkg::*; #(
	parameter int CACHE_SIZE = 64,
	parameter int BLOCK_SIZE = 4
) (
	input logic tb_CLK,
	input logic rst_n,
	cache_array_if.tag arr
);

	localparam int num_sets = CACHE_SIZE / (BLOCK_SIZE * num_ways);

	// Status bits, cleared by reset and by invalidate-all
	logic [num_sets-1:0][num_ways-1:0] valid;
	logic [num_sets-1:0][num_ways-1:0] dirty;
	// Index of the least recently used way
	logic [num_sets-1:0] lru;
	// Tag storage
	logic [addr_width-1:0] tags [num_sets][num_ways];

	logic [num_ways-1:0] match;

	// Compare both ways of the indexed set
	always_comb
	begin
		for (int w = 0; w < num_ways; w++)
		begin
			match[w] = valid[arr.index][w] && (tags[arr.index][w] == arr.lookup_tag);
		end
	end

	assign arr.hit = |match;
	// Way 1 when it matches, else way 0
	assign arr.hit_way = match[1];

	// Empty way first, otherwise the LRU way
	always_comb
	begin
		if (!valid[arr.index][0])
			arr.victim_way = 1'b0;
		else if (!valid[arr.index][1])
			arr.victim_way = 1'b1;
		else
			arr.victim_way = lru[arr.index];
	end

	// Metadata of the way the controller selects
	assign arr.victim_meta = '{
		valid: valid[arr.index][arr.way_sel],
		dirty: dirty[arr.index][arr.way_sel],
		tag:   tags[arr.index][arr.way_sel]
	};

	always_ff @(posedge tb_CLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			valid <= '0;
			dirty <= '0;
			lru <= '0;
		end
		else if (arr.inv_all)
		begin
			// LRU order kept, lines dropped
			valid <= '0;
			dirty <= '0;
		end
		else
		begin
			if (arr.tag_we)
			begin
				valid[arr.index][arr.way_sel] <= arr.new_meta.valid;
				dirty[arr.index][arr.way_sel] <= arr.new_meta.dirty;
			end
			// Other way becomes least recently used
			if (arr.lru_we)
				lru[arr.index] <= ~arr.way_sel;
		end
	end

	// Tag write on install or metadata update
	always_ff @(posedge tb_CLK)
	begin
		if (arr.tag_we)
			tags[arr.index][arr.way_sel] <= arr.new_meta.tag;
	end

endmodule

/* verilog/l1_cache_ctrl.sv */
/*
 * L1 cache controller
 * FSM for hits, line write-back and fill, uncached bypass,
 * flush and clear
 */

`timescale 1ns/1ps

module l1_cache_ctrl import bus_pkg::*, cache_pkg::*; #(
	parameter int CACHE_SIZE = 64,
	parameter int BLOCK_SIZE = 4,
	parameter logic [addr_width-1:0] NONCACHE_START_ADDR = 32'h8000_0000
) (
	input logic tb_CLK,
	input logic rst_n,
	input logic [addr_width-1:0] proc_addr,
	input logic [data_width-1:0] proc_wdata,
	input logic proc_ren,
	input logic proc_wen,
	output logic [data_width-1:0] proc_rdata,
	output logic proc_busy,
	input logic [data_width-1:0] mem_rdata,
	input logic mem_busy,
	output logic [addr_width-1:0] mem_addr,
	output logic [data_width-1:0] mem_wdata,
	output logic mem_ren,
	output logic mem_wen,
	input logic flush,
	input logic clear,
	output logic flush_done,
	output logic clear_done,
	cache_array_if.ctrl arr
);

	localparam int num_sets = CACHE_SIZE / (BLOCK_SIZE * num_ways);
	localparam int idx_w = $clog2(num_sets);
	localparam int off_w = $clog2(BLOCK_SIZE);
	localparam int tag_w = addr_width - idx_w - off_w - 2;

	cache_state_t state, next_state;
	mem_op_t mem_op;

	// Miss way, word counter and flush scan position
	logic miss_way;
	logic [off_w-1:0] wcnt;
	logic [idx_w-1:0] scan_set;
	logic scan_way;
	// Set when the running maintenance op is a flush
	logic op_flush;

	// Address fields
	logic [idx_w-1:0] proc_idx;
	logic [off_w-1:0] proc_off;
	logic [addr_width-1:0] proc_tag;
	logic req;
	logic cacheable;
	logic last_word;
	logic last_scan;
	logic sel_dirty;
	logic word_step;
	logic scan_step;

	assign proc_idx = proc_addr[idx_w+off_w+1 -: idx_w];
	assign proc_off = proc_addr[off_w+1 -: off_w];
	assign proc_tag = proc_addr >> (idx_w + off_w + 2);
	assign req = proc_ren | proc_wen;
	assign cacheable = proc_addr < NONCACHE_START_ADDR;

	assign last_word = wcnt == off_w'(BLOCK_SIZE - 1);
	assign last_scan = (scan_set == idx_w'(num_sets - 1)) && scan_way;
	// Selected way holds modified data
	assign sel_dirty = arr.victim_meta.valid && arr.victim_meta.dirty;

	// Counters move on each accepted line word or clean scan slot
	assign word_step = (state inside {s_writeback, s_fill, s_flush_wb}) && !mem_busy;
	assign scan_step = (state == s_flush_scan) && !sel_dirty;

	assign mem_ren = (mem_op == mem_fill) || (mem_op == mem_bypass_rd);
	assign mem_wen = (mem_op == mem_writeback) || (mem_op == mem_bypass_wr);

	// Done pulses come from the single s_done cycle
	assign flush_done = (state == s_done) && op_flush;
	assign clear_done = (state == s_done) && !op_flush;

	always_comb
	begin
		next_state = state;
		mem_op = mem_idle;
		// Lookup follows the processor address by default
		arr.index = proc_idx;
		arr.lookup_tag = proc_tag;
		arr.offset = proc_off;
		arr.way_sel = miss_way;
		arr.data_we = 1'b0;
		arr.wdata = proc_wdata;
		arr.tag_we = 1'b0;
		arr.new_meta = '{valid: 1'b1, dirty: 1'b0, tag: proc_tag};
		arr.lru_we = 1'b0;
		arr.inv_all = 1'b0;
		proc_busy = 1'b1;
		proc_rdata = arr.rdata;
		mem_addr = proc_addr;
		mem_wdata = arr.rdata;

		case (state)
			s_idle:
			begin
				arr.way_sel = arr.hit ? arr.hit_way : arr.victim_way;
				// Maintenance strobes win over a new access
				if (flush)
					next_state = s_flush_scan;
				else if (clear)
					next_state = s_clear;
				else if (!req)
					proc_busy = 1'b0;
				else if (!cacheable)
					next_state = s_bypass;
				else if (arr.hit)
				begin
					// Hit completes this cycle
					proc_busy = 1'b0;
					arr.lru_we = 1'b1;
					if (proc_wen)
					begin
						arr.data_we = 1'b1;
						arr.tag_we = 1'b1;
						arr.new_meta.dirty = 1'b1;
					end
				end
				else if (sel_dirty)
					next_state = s_writeback;
				else
					next_state = s_fill;
			end

			s_writeback:
			begin
				mem_op = mem_writeback;
				arr.offset = wcnt;
				mem_addr = {arr.victim_meta.tag[tag_w-1:0], proc_idx, wcnt, 2'b00};
				if (!mem_busy && last_word)
					next_state = s_fill;
			end

			s_fill:
			begin
				mem_op = mem_fill;
				arr.offset = wcnt;
				arr.wdata = mem_rdata;
				mem_addr = {proc_tag[tag_w-1:0], proc_idx, wcnt, 2'b00};
				if (!mem_busy)
				begin
					arr.data_we = 1'b1;
					// Install clean line with the last word, hit follows in idle
					if (last_word)
					begin
						arr.tag_we = 1'b1;
						next_state = s_idle;
					end
				end
			end

			s_bypass:
			begin
				mem_op = proc_wen ? mem_bypass_wr : mem_bypass_rd;
				mem_wdata = proc_wdata;
				proc_rdata = mem_rdata;
				// Processor completes with the memory word
				if (!mem_busy)
				begin
					proc_busy = 1'b0;
					next_state = s_idle;
				end
			end

			s_flush_scan:
			begin
				arr.index = scan_set;
				arr.way_sel = scan_way;
				if (sel_dirty)
					next_state = s_flush_wb;
				else if (last_scan)
				begin
					arr.inv_all = 1'b1;
					next_state = s_done;
				end
			end

			s_flush_wb:
			begin
				mem_op = mem_writeback;
				arr.index = scan_set;
				arr.way_sel = scan_way;
				arr.offset = wcnt;
				mem_addr = {arr.victim_meta.tag[tag_w-1:0], scan_set, wcnt, 2'b00};
				// Line now clean, scan resumes at the same slot
				if (!mem_busy && last_word)
				begin
					arr.tag_we = 1'b1;
					arr.new_meta = '{valid: 1'b1, dirty: 1'b0, tag: arr.victim_meta.tag};
					next_state = s_flush_scan;
				end
			end

			s_clear:
			begin
				// Dirty data dropped
				arr.inv_all = 1'b1;
				next_state = s_done;
			end

			s_done:
				next_state = s_idle;

			default:
				next_state = s_idle;
		endcase
	end

	always_ff @(posedge tb_CLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= s_idle;
			miss_way <= 1'b0;
			wcnt <= '0;
			scan_set <= '0;
			scan_way <= 1'b0;
			op_flush <= 1'b0;
		end
		else
		begin
			state <= next_state;
			if (state == s_idle)
			begin
				// Victim held for the whole miss
				miss_way <= arr.victim_way;
				wcnt <= '0;
				scan_set <= '0;
				scan_way <= 1'b0;
				op_flush <= flush;
			end
			// Wraps to zero after the last word of a line
			if (word_step)
				wcnt <= wcnt + 1'b1;
			if (scan_step)
				{scan_set, scan_way} <= {scan_set, scan_way} + 1'b1;
		end
	end

endmodule

/* verilog/l1_cache_top.sv */
/*
 * L1 cache top level
 * Two-way write-back cache on plain processor and memory word buses
 */

`timescale 1ns/1ps

module l1_cache_top import bus_pkg::*; #(
	parameter int CACHE_SIZE = 64,
	parameter int BLOCK_SIZE = 4,
	parameter logic [addr_width-1:0] NONCACHE_START_ADDR = 32'h8000_0000
) (
	input logic tb_CLK,
	input logic rst_n,
	// Processor side
	input logic [addr_width-1:0] proc_addr,
	input logic [data_width-1:0] proc_wdata,
	input logic proc_ren,
	input logic proc_wen,
	output logic [data_width-1:0] proc_rdata,
	output logic proc_busy,
	// Memory side
	output logic [addr_width-1:0] mem_addr,
	output logic [data_width-1:0] mem_wdata,
	output logic mem_ren,
	output logic mem_wen,
	input logic [data_width-1:0] mem_rdata,
	input logic mem_busy,
	// Maintenance
	input logic flush,
	input logic clear,
	output logic flush_done,
	output logic clear_done
);

	cache_array_if #(
		.CACHE_SIZE(CACHE_SIZE),
		.BLOCK_SIZE(BLOCK_SIZE)
	) arr_if ();

	// Controller and FSM
	l1_cache_ctrl #(
		.CACHE_SIZE(CACHE_SIZE),
		.BLOCK_SIZE(BLOCK_SIZE),
		.NONCACHE_START_ADDR(NONCACHE_START_ADDR)
	) ctrl_i (
		.tb_CLK(tb_CLK),
		.rst_n(rst_n),
		.proc_addr(proc_addr),
		.proc_wdata(proc_wdata),
		.proc_ren(proc_ren),
		.proc_wen(proc_wen),
		.proc_rdata(proc_rdata),
		.proc_busy(proc_busy),
		.mem_rdata(mem_rdata),
		.mem_busy(mem_busy),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_ren(mem_ren),
		.mem_wen(mem_wen),
		.flush(flush),
		.clear(clear),
		.flush_done(flush_done),
		.clear_done(clear_done),
		.arr(arr_if.ctrl)
	);

	// Metadata and hit logic
	cache_tag_array #(
		.CACHE_SIZE(CACHE_SIZE),
		.BLOCK_SIZE(BLOCK_SIZE)
	) tag_i (
		.tb_CLK(tb_CLK),
		.rst_n(rst_n),
		.arr(arr_if.tag)
	);

	// Line words
	cache_data_array #(
		.CACHE_SIZE(CACHE_SIZE),
		.BLOCK_SIZE(BLOCK_SIZE)
	) data_i (
		.tb_CLK(tb_CLK),
		.arr(arr_if.data)
	);

endmodule
